//--- eth_rx_pkg.sv
package eth_rx_pkg;

	//////////////////////////////////////////////////////////////////////////
	// Shared types

	// One word of the receive stream
	// Bits 31:24 of data carry the first byte on the wire
	typedef struct packed {
		logic [31:0] data;
		// Marks the final word of a frame
		logic        last;
		// Valid bytes in a last word, zero stands for all four
		logic [1:0]  nbytes;
	} rx_word_t;

	// Frame length in bytes, up to 1536
	typedef logic [10:0] frame_len_t;

	// Management bus address
	typedef logic [15:0] mgmt_addr_t;

	//////////////////////////////////////////////////////////////////////////
	// Management register map

	// Interrupt status, bit 0 = received frame pending
	localparam mgmt_addr_t REG_FPGA_IRQSTAT   = 16'h0020;
	localparam mgmt_addr_t REG_FPGA_IRQSTAT_1 = 16'h0021;

	// Pending frame length, reading the upper byte pops the header
	localparam mgmt_addr_t REG_EMAC_RXLEN     = 16'h0024;
	localparam mgmt_addr_t REG_EMAC_RXLEN_1   = 16'h0025;

	// Frame body window
	// Low two address bits pick the byte lane of the head word
	localparam mgmt_addr_t REG_EMAC_BUFFER_LO = 16'h1000;
	localparam mgmt_addr_t REG_EMAC_BUFFER_HI = 16'h1FFF;

	//////////////////////////////////////////////////////////////////////////
	// Buffer sizing

	// Data FIFO in 32-bit words
	localparam int DATA_FIFO_DEPTH = 1024;

	// Header FIFO in frame lengths
	localparam int HDR_FIFO_DEPTH = 16;

	// Largest frame handled
	localparam int ETH_MAX_BYTES = 1536;

	// Words needed to hold a largest frame, also the admission threshold
	localparam int ETH_MAX_WORDS = ETH_MAX_BYTES / 4;

	// Width of the data FIFO free count, covers 0 through DEPTH
	localparam int DATA_CNT_W = $clog2(DATA_FIFO_DEPTH + 1);

endpackage

//--- sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
	parameter type T     = logic [31:0],
	parameter int  DEPTH = 16
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       push,
	input  T                           push_data,
	input  logic                       pop,
	output T                           head,
	output logic                       empty,
	output logic                       full,
	output logic [$clog2(DEPTH+1)-1:0] free
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [CNT_W-1:0] DEPTH_C = CNT_W'(DEPTH);

	// Storage, no reset on the payload
	T mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] rd_ptr_n;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_n;
	logic             do_push;
	logic             do_pop;

	// Circular increment, depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + PTR_W'(1);
	endfunction

	//////////////////////////////////////////////////////////////////////////
	// Occupancy

	// Overflow and underflow are ignored here
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign rd_ptr_n = do_pop ? ptr_inc(rd_ptr) : rd_ptr;
	assign count_n  = count + CNT_W'(do_push) - CNT_W'(do_pop);

	assign empty = (count == '0);
	assign full  = (count == DEPTH_C);
	assign free  = DEPTH_C - count;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			rd_ptr <= rd_ptr_n;
			count  <= count_n;
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// Storage and registered head

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// Head always holds the oldest entry, refreshed every edge
	// A push into an otherwise empty FIFO bypasses the array
	always_ff @(posedge clk) begin
		if (count_n != '0) begin
			if (do_push && (wr_ptr == rd_ptr_n)) begin
				head <= push_data;
			end else begin
				head <= mem[rd_ptr_n];
			end
		end
	end

	// Producers must check space before pushing
	assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
		else $error("sync_fifo push while full");

	// Consumers must check for data before popping
	assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
		else $error("sync_fifo pop while empty");

endmodule

//--- rx_frame_writer.sv
`timescale 1ns/1ps

module rx_frame_writer (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              rx_valid,
	input  eth_rx_pkg::rx_word_t              rx_word,
	input  logic [eth_rx_pkg::DATA_CNT_W-1:0] data_free,
	input  logic                              hdr_full,
	output logic                              data_push,
	output logic [31:0]                       data_word,
	output logic                              hdr_push,
	output eth_rx_pkg::frame_len_t            hdr_len,
	output logic [15:0]                       drop_count
);

	import eth_rx_pkg::*;

	// Frame tracking state
	logic       in_frame;
	logic       admit;
	frame_len_t byte_cnt;

	logic        first_word;
	logic        room_ok;
	logic        admit_now;
	logic [2:0]  word_bytes;
	logic [11:0] byte_sum;
	logic [31:0] lane_mask;

	//////////////////////////////////////////////////////////////////////////
	// Admission

	assign first_word = rx_valid && !in_frame;

	// Room for a whole largest frame plus one header slot
	// so an admitted frame never needs a rollback
	assign room_ok = !hdr_full && (data_free >= DATA_CNT_W'(ETH_MAX_WORDS));

	// First word decides, later words follow that decision
	assign admit_now = in_frame ? admit : room_ok;

	//////////////////////////////////////////////////////////////////////////
	// Byte accounting and padding

	always_comb begin
		word_bytes = 3'd4;
		if (rx_word.last && (rx_word.nbytes != 2'd0)) begin
			word_bytes = {1'b0, rx_word.nbytes};
		end
		// Data is left-justified, clear the trailing lanes
		case (word_bytes)
			3'd1:    lane_mask = 32'hFF00_0000;
			3'd2:    lane_mask = 32'hFFFF_0000;
			3'd3:    lane_mask = 32'hFFFF_FF00;
			default: lane_mask = 32'hFFFF_FFFF;
		endcase
	end

	// One spare bit so an oversize frame is visible
	assign byte_sum = {1'b0, byte_cnt} + 12'(word_bytes);

	assign data_push = rx_valid && admit_now;
	assign data_word = rx_word.data & lane_mask;

	// Length is committed together with the last word
	assign hdr_push = data_push && rx_word.last;
	assign hdr_len  = byte_sum[10:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_frame   <= 1'b0;
			admit      <= 1'b0;
			byte_cnt   <= '0;
			drop_count <= '0;
		end else if (rx_valid) begin
			in_frame <= !rx_word.last;
			if (first_word) begin
				admit <= room_ok;
			end
			byte_cnt <= rx_word.last ? '0 : byte_sum[10:0];
			// One count per refused frame, held at all ones
			if (first_word && !room_ok && (drop_count != 16'hFFFF)) begin
				drop_count <= drop_count + 16'd1;
			end
		end
	end

	// Stream must not deliver frames beyond the maximum size
	assert property (@(posedge clk) disable iff (!rst_n)
		data_push |-> (byte_sum <= 12'(ETH_MAX_BYTES)))
		else $error("rx frame longer than %0d bytes", ETH_MAX_BYTES);

endmodule

//--- mgmt_reg_if.sv
`timescale 1ns/1ps

module mgmt_reg_if (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   frame_commit,
	output logic                   irq,
	input  logic                   rd_en,
	input  eth_rx_pkg::mgmt_addr_t rd_addr,
	output logic                   rd_valid,
	output logic [7:0]             rd_data,
	input  logic [31:0]            data_head,
	input  logic                   data_empty,
	output logic                   data_pop,
	input  eth_rx_pkg::frame_len_t hdr_head,
	input  logic                   hdr_empty,
	output logic                   hdr_pop
);

	import eth_rx_pkg::*;

	logic       in_buffer;
	logic [7:0] rd_data_n;
	logic       irq_clear;

	//////////////////////////////////////////////////////////////////////////
	// Address decode

	// Whole window aliases the head of the data FIFO
	assign in_buffer = (rd_addr >= REG_EMAC_BUFFER_LO) && (rd_addr <= REG_EMAC_BUFFER_HI);

	// Read data, pops and the interrupt clear are all decided
	// in the rd_en cycle and take effect on the following edge
	always_comb begin
		rd_data_n = 8'h00;
		irq_clear = 1'b0;
		data_pop  = 1'b0;
		hdr_pop   = 1'b0;

		if (rd_en) begin
			if (in_buffer) begin
				// Bytes in arrival order, no endianness swap
				if (!data_empty) begin
					case (rd_addr[1:0])
						2'd0: rd_data_n = data_head[31:24];
						2'd1: rd_data_n = data_head[23:16];
						2'd2: rd_data_n = data_head[15:8];
						2'd3: begin
							rd_data_n = data_head[7:0];
							// Last lane consumes the word
							data_pop  = 1'b1;
						end
						default: rd_data_n = 8'h00;
					endcase
				end
			end else begin
				case (rd_addr)
					REG_FPGA_IRQSTAT: begin
						// Bit 0 = at least one frame waiting
						rd_data_n = {7'b0, !hdr_empty};
						irq_clear = 1'b1;
					end
					REG_FPGA_IRQSTAT_1: begin
						rd_data_n = 8'h00;
					end
					REG_EMAC_RXLEN: begin
						if (!hdr_empty) begin
							rd_data_n = hdr_head[7:0];
						end
					end
					REG_EMAC_RXLEN_1: begin
						// Upper length bits, then the header is done
						if (!hdr_empty) begin
							rd_data_n = {5'b0, hdr_head[10:8]};
							hdr_pop   = 1'b1;
						end
					end
					default: begin
						rd_data_n = 8'h00;
					end
				endcase
			end
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// Read response and interrupt

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_valid <= 1'b0;
			rd_data  <= 8'h00;
		end else begin
			// Every read completes in one cycle
			rd_valid <= rd_en;
			if (rd_en) begin
				rd_data <= rd_data_n;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			irq <= 1'b0;
		end else if (frame_commit) begin
			// New frame wins over a clear on the same edge
			irq <= 1'b1;
		end else if (irq_clear) begin
			irq <= 1'b0;
		end
	end

endmodule

//--- eth_rx_mgmt_top.sv
`timescale 1ns/1ps

module eth_rx_mgmt_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   rx_valid,
	input  eth_rx_pkg::rx_word_t   rx_word,
	input  logic                   rd_en,
	input  eth_rx_pkg::mgmt_addr_t rd_addr,
	output logic                   rd_valid,
	output logic [7:0]             rd_data,
	output logic                   irq,
	output logic [15:0]            drop_count
);

	import eth_rx_pkg::*;

	// Writer to data FIFO
	logic                  data_push;
	logic [31:0]           data_word;
	logic [DATA_CNT_W-1:0] data_free;

	// Data FIFO to register port
	logic [31:0] data_head;
	logic        data_empty;
	logic        data_pop;

	// Header FIFO in both directions
	logic       hdr_push;
	frame_len_t hdr_len;
	logic       hdr_full;
	frame_len_t hdr_head;
	logic       hdr_empty;
	logic       hdr_pop;

	//////////////////////////////////////////////////////////////////////////
	// Receive path

	rx_frame_writer u_writer (
		.clk        (clk),
		.rst_n      (rst_n),
		.rx_valid   (rx_valid),
		.rx_word    (rx_word),
		.data_free  (data_free),
		.hdr_full   (hdr_full),
		.data_push  (data_push),
		.data_word  (data_word),
		.hdr_push   (hdr_push),
		.hdr_len    (hdr_len),
		.drop_count (drop_count)
	);

	// Frame bodies, one word per entry
	sync_fifo #(
		.T     (logic [31:0]),
		.DEPTH (DATA_FIFO_DEPTH)
	) u_data_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (data_push),
		.push_data (data_word),
		.pop       (data_pop),
		.head      (data_head),
		.empty     (data_empty),
		.full      (),
		.free      (data_free)
	);

	// Frame lengths, one entry per committed frame
	sync_fifo #(
		.T     (frame_len_t),
		.DEPTH (HDR_FIFO_DEPTH)
	) u_hdr_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (hdr_push),
		.push_data (hdr_len),
		.pop       (hdr_pop),
		.head      (hdr_head),
		.empty     (hdr_empty),
		.full      (hdr_full),
		.free      ()
	);

	//////////////////////////////////////////////////////////////////////////
	// Host side

	mgmt_reg_if u_mgmt (
		.clk          (clk),
		.rst_n        (rst_n),
		.frame_commit (hdr_push),
		.irq          (irq),
		.rd_en        (rd_en),
		.rd_addr      (rd_addr),
		.rd_valid     (rd_valid),
		.rd_data      (rd_data),
		.data_head    (data_head),
		.data_empty   (data_empty),
		.data_pop     (data_pop),
		.hdr_head     (hdr_head),
		.hdr_empty    (hdr_empty),
		.hdr_pop      (hdr_pop)
	);

endmodule

//--- tb_eth_rx_mgmt.sv
`timescale 1ns/1ps

module tb_eth_rx_mgmt;

	import eth_rx_pkg::*;

	typedef logic [7:0]  byte_q_t[$];
	typedef logic [31:0] word_q_t[$];

	logic       clk;
	logic       rst_n;
	logic       rx_valid;
	rx_word_t   rx_word;
	logic       rd_en;
	mgmt_addr_t rd_addr;
	logic       rd_valid;
	logic [7:0] rd_data;
	logic       irq;
	logic [15:0] drop_count;

	// Model of what the DUT holds
	frame_len_t len_q[$];
	logic [7:0] body_q[$];
	logic [7:0] exp_q[$];
	int         hdr_count;
	int         data_words;
	int         drops;

	int   err_data;
	int   err_proto;
	logic prev_rd_en;

	eth_rx_mgmt_top UUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.rx_valid   (rx_valid),
		.rx_word    (rx_word),
		.rd_en      (rd_en),
		.rd_addr    (rd_addr),
		.rd_valid   (rd_valid),
		.rd_data    (rd_data),
		.irq        (irq),
		.drop_count (drop_count)
	);

	always #5 clk = ~clk;

	//////////////////////////////////////////////////////////////////////////
	// Reference model

	// Zero pad to whole words with the first byte in the top lane
	function automatic void pack_frame(input byte_q_t b, output word_q_t words,
		output byte_q_t padded);
		int i;
		padded = b;
		while ((padded.size() % 4) != 0) begin
			padded.push_back(8'h00);
		end
		words = {};
		for (i = 0; i < padded.size(); i += 4) begin
			words.push_back({padded[i], padded[i+1], padded[i+2], padded[i+3]});
		end
	endfunction

	function automatic byte_q_t make_frame(input int len);
		byte_q_t b;
		int      i;
		for (i = 0; i < len; i++) begin
			b.push_back(8'($urandom));
		end
		return b;
	endfunction

	// Admission is decided once per frame against current occupancy
	task automatic model_offer(input int len, input int nwords, input byte_q_t padded);
		if ((hdr_count < HDR_FIFO_DEPTH) &&
			((DATA_FIFO_DEPTH - data_words) >= ETH_MAX_WORDS)) begin
			len_q.push_back(11'(len));
			foreach (padded[i]) begin
				body_q.push_back(padded[i]);
			end
			hdr_count++;
			data_words += nwords;
		end else begin
			drops++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////////
	// Receive stream driver

	task automatic send_frame(input byte_q_t bytes);
		word_q_t  words;
		byte_q_t  padded;
		rx_word_t w;
		int       nw;
		int       rem;
		int       i;
		pack_frame(bytes, words, padded);
		model_offer(bytes.size(), words.size(), padded);
		nw  = words.size();
		rem = bytes.size() % 4;
		for (i = 0; i < nw; i++) begin
			w.data   = words[i];
			w.last   = (i == nw - 1);
			w.nbytes = w.last ? 2'(rem) : 2'd0;
			// Junk in the unused lanes that the writer must clear
			if (w.last && (rem != 0)) begin
				w.data = w.data | ($urandom & (32'hFFFF_FFFF >> (8 * rem)));
			end
			@(posedge clk);
			rx_valid <= 1'b1;
			rx_word  <= w;
		end
	endtask

	task automatic rx_idle();
		@(posedge clk);
		rx_valid <= 1'b0;
		rx_word  <= '0;
	endtask

	//////////////////////////////////////////////////////////////////////////
	// Host reads

	task automatic issue_read(input mgmt_addr_t addr, input logic [7:0] expected);
		@(posedge clk);
		rd_en   <= 1'b1;
		rd_addr <= addr;
		exp_q.push_back(expected);
	endtask

	task automatic read_idle();
		@(posedge clk);
		rd_en   <= 1'b0;
		rd_addr <= '0;
	endtask

	task automatic finish_run();
		$display("errors: data %0d, protocol %0d", err_data, err_proto);
		if ((err_data + err_proto) == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	endtask

	// All issued reads answered
	task automatic wait_drain();
		int n;
		for (n = 0; n < 20; n++) begin
			@(negedge clk);
			if (exp_q.size() == 0) begin
				return;
			end
		end
		$display("timeout: read responses did not arrive");
		err_proto++;
		finish_run();
	endtask

	task automatic wait_irq();
		int n;
		for (n = 0; n < 50; n++) begin
			@(negedge clk);
			if (irq) begin
				return;
			end
		end
		$display("timeout: irq did not rise after a frame");
		err_proto++;
		finish_run();
	endtask

	// Status read that must leave irq low
	task automatic read_irqstat();
		issue_read(REG_FPGA_IRQSTAT, {7'b0, hdr_count != 0});
		read_idle();
		wait_drain();
		@(negedge clk);
		assert (irq == 1'b0) else begin
			$display("ERR irq: got %h expected %h", irq, 1'b0);
			err_data++;
		end
	endtask

	// Length then body, lane bits walk 0..3 at random window addresses
	task automatic read_frame();
		frame_len_t len;
		int         nw;
		int         i;
		mgmt_addr_t a;
		len = len_q.pop_front();
		issue_read(REG_EMAC_RXLEN, len[7:0]);
		issue_read(REG_EMAC_RXLEN_1, {5'b0, len[10:8]});
		hdr_count--;
		nw = (len + 3) / 4;
		for (i = 0; i < nw * 4; i++) begin
			a = REG_EMAC_BUFFER_LO | (16'($urandom) & 16'h0FFC) | 16'(i % 4);
			issue_read(a, body_q.pop_front());
		end
		data_words -= nw;
		read_idle();
		wait_drain();
	endtask

	task automatic check_drops();
		@(negedge clk);
		assert (drop_count == 16'(drops)) else begin
			$display("ERR drop_count: got %h expected %h", drop_count, 16'(drops));
			err_data++;
		end
	endtask

	task automatic run_frame(input int len);
		send_frame(make_frame(len));
		rx_idle();
		wait_irq();
		read_irqstat();
		read_frame();
		read_irqstat();
	endtask

	//////////////////////////////////////////////////////////////////////////
	// Comparator sampling on the falling edge

	always @(negedge clk) begin : compare
		logic [7:0] expected;
		// Response exactly one cycle after the strobe
		assert (rd_valid == prev_rd_en) else begin
			$display("ERR rd_valid: got %h expected %h", rd_valid, prev_rd_en);
			err_proto++;
		end
		if (rd_valid) begin
			if (exp_q.size() == 0) begin
				$display("read response arrived with no read outstanding");
				err_proto++;
			end else begin
				expected = exp_q.pop_front();
				assert (rd_data == expected) else begin
					$display("ERR rd_data: got %h expected %h", rd_data, expected);
					err_data++;
				end
			end
		end
		prev_rd_en = rd_en;
	end

	//////////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		int i;
		mgmt_addr_t odd_addr[6];
		void'($urandom(32'hd116765c));
		odd_addr   = '{16'h0000, 16'h0022, 16'h0026, 16'h0FFF, 16'h2000, 16'hFFFF};
		clk        = 1'b0;
		prev_rd_en = 1'b0;
		err_data   = 0;
		err_proto  = 0;
		hdr_count  = 0;
		data_words = 0;
		drops      = 0;
		rst_n    <= 1'b0;
		rx_valid <= 1'b0;
		rx_word  <= '0;
		rd_en    <= 1'b0;
		rd_addr  <= '0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		// Idle state after reset
		@(negedge clk);
		assert (!irq && !rd_valid) else begin
			$display("ERR irq/rd_valid: got %h expected %h", {irq, rd_valid}, 2'b00);
			err_data++;
		end
		issue_read(REG_FPGA_IRQSTAT, 8'h00);
		issue_read(REG_EMAC_RXLEN, 8'h00);
		read_idle();
		wait_drain();

		// Single frames of lengths 1 to 4 and then random sizes
		for (i = 1; i <= 4; i++) begin
			run_frame(i);
		end
		for (i = 0; i < 6; i++) begin
			run_frame(1 + ($urandom % ETH_MAX_BYTES));
		end

		// Back to back frames read out afterwards
		for (i = 0; i < 5; i++) begin
			send_frame(make_frame(1 + ($urandom % 200)));
		end
		rx_idle();
		wait_irq();
		read_irqstat();
		while (len_q.size() > 0) begin
			read_frame();
		end
		read_irqstat();

		// Header FIFO overflow where the 17th frame is refused
		for (i = 0; i < 17; i++) begin
			send_frame(make_frame(1 + ($urandom % 64)));
		end
		rx_idle();
		wait_irq();
		check_drops();
		read_irqstat();
		while (len_q.size() > 0) begin
			read_frame();
		end

		// Third largest frame finds too little data FIFO room
		for (i = 0; i < 3; i++) begin
			send_frame(make_frame(ETH_MAX_BYTES));
		end
		rx_idle();
		wait_irq();
		check_drops();
		read_irqstat();
		while (len_q.size() > 0) begin
			read_frame();
		end
		read_irqstat();

		// Unmapped and empty reads give zero
		foreach (odd_addr[k]) begin
			issue_read(odd_addr[k], 8'h00);
		end
		issue_read(REG_FPGA_IRQSTAT_1, 8'h00);
		issue_read(REG_EMAC_RXLEN, 8'h00);
		issue_read(REG_EMAC_RXLEN_1, 8'h00);
		for (i = 0; i < 8; i++) begin
			issue_read(REG_EMAC_BUFFER_LO | (16'($urandom) & 16'h0FFF), 8'h00);
		end
		read_idle();
		wait_drain();
		// Later frame unaffected
		run_frame(1 + ($urandom % 100));
		check_drops();

		finish_run();
	end

endmodule

//--- tb.f
eth_rx_pkg.sv
sync_fifo.sv
rx_frame_writer.sv
mgmt_reg_if.sv
eth_rx_mgmt_top.sv
tb_eth_rx_mgmt.sv
